//--- common/rv_isa_pkg.sv
package rv_isa_pkg;

    // Widths with a meaning of their own
    typedef logic [31:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [2:0]  res_src_t;

    // Load and store access size codes
    localparam funct3_t f3_byte   = 3'd0;
    localparam funct3_t f3_half   = 3'd1;
    localparam funct3_t f3_word   = 3'd2;
    localparam funct3_t f3_byte_u = 3'd4;
    localparam funct3_t f3_half_u = 3'd5;

    // Writeback result sources
    localparam res_src_t res_alu       = 3'd0;
    localparam res_src_t res_dmem      = 3'd1;
    localparam res_src_t res_pc_plus4  = 3'd2;
    localparam res_src_t res_jb_target = 3'd3;
    localparam res_src_t res_csr       = 3'd4;
    localparam res_src_t res_m         = 3'd5;

    // ADDI x0, x0, 0
    localparam instr_t instr_nop = 32'h0000_0013;

endpackage

//--- common/rv_pipe_pkg.sv
package rv_pipe_pkg;

    // One instruction leaving execute
    typedef struct packed {
        logic                   reg_write;
        logic                   mem_read;
        logic                   mem_write;
        rv_isa_pkg::res_src_t   res_src;
        rv_isa_pkg::funct3_t    funct3;
        rv_isa_pkg::instr_t     instr;
        rv_isa_pkg::reg_addr_t  rd;
        rv_isa_pkg::word_t      alu_result;
        rv_isa_pkg::word_t      store_data;
        rv_isa_pkg::word_t      pc_plus4;
        rv_isa_pkg::word_t      jb_target;
        rv_isa_pkg::word_t      csr_rdata;
        rv_isa_pkg::word_t      m_result;
    } exmem_t;

    // One instruction leaving the memory stage
    typedef struct packed {
        logic                   reg_write;
        rv_isa_pkg::res_src_t   res_src;
        rv_isa_pkg::funct3_t    funct3;
        rv_isa_pkg::instr_t     instr;
        rv_isa_pkg::reg_addr_t  rd;
        rv_isa_pkg::word_t      alu_result;
        rv_isa_pkg::word_t      dmem_rdata_ext;
        rv_isa_pkg::word_t      pc_plus4;
        rv_isa_pkg::word_t      jb_target;
        rv_isa_pkg::word_t      csr_rdata;
        rv_isa_pkg::word_t      m_result;
    } memwb_t;

endpackage

//--- hw/mem/rv_dmem.sv
`timescale 1ns/1ns

module rv_dmem #(
    parameter int DEPTH_WORDS = 256
) (
    input  logic              clk,
    input  rv_isa_pkg::word_t addr,
    input  logic [3:0]        byte_en,
    input  rv_isa_pkg::word_t wdata,
    output rv_isa_pkg::word_t rdata
);

    // Index width, at least one bit
    localparam int AW = (DEPTH_WORDS > 1) ? $clog2(DEPTH_WORDS) : 1;

    rv_isa_pkg::word_t mem [DEPTH_WORDS];
    logic [AW-1:0]     idx;

    // Address is already reduced to the array range by the caller
    assign idx = addr[AW-1:0];

    // Asynchronous read of the whole word
    assign rdata = mem[idx];

    // Each enabled lane is written on the edge
    always_ff @(posedge clk) begin
        if (byte_en[0]) begin
            mem[idx][7:0] <= wdata[7:0];
        end
        if (byte_en[1]) begin
            mem[idx][15:8] <= wdata[15:8];
        end
        if (byte_en[2]) begin
            mem[idx][23:16] <= wdata[23:16];
        end
        if (byte_en[3]) begin
            mem[idx][31:24] <= wdata[31:24];
        end
    end

endmodule

//--- hw/mem/rv_mem_stage.sv
`timescale 1ns/1ns

module rv_mem_stage #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                clk,
    input  rv_pipe_pkg::exmem_t ex_mem,
    output rv_pipe_pkg::memwb_t mem_wb_d
);

    rv_isa_pkg::word_t dmem_addr;
    rv_isa_pkg::word_t dmem_wdata;
    rv_isa_pkg::word_t dmem_rdata;
    rv_isa_pkg::word_t load_ext;
    logic [3:0]        dmem_be;
    logic [3:0]        size_be;
    logic [1:0]        byte_off;
    logic [7:0]        load_byte;
    logic [15:0]       load_half;

    assign byte_off = ex_mem.alu_result[1:0];

    // Word index wraps around the memory size
    assign dmem_addr = (ex_mem.alu_result >> 2) % rv_isa_pkg::word_t'(DMEM_WORDS);

    // Store data replicated into every lane, byte enable picks the lane
    always_comb begin
        case (ex_mem.funct3)
            rv_isa_pkg::f3_byte: begin
                dmem_wdata = {4{ex_mem.store_data[7:0]}};
                size_be    = 4'b0001 << byte_off;
            end
            rv_isa_pkg::f3_half: begin
                dmem_wdata = {2{ex_mem.store_data[15:0]}};
                size_be    = byte_off[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                dmem_wdata = ex_mem.store_data;
                size_be    = 4'b1111;
            end
        endcase
    end

    // Nothing is written unless this is a store
    assign dmem_be = ex_mem.mem_write ? size_be : 4'b0000;

    rv_dmem #(
        .DEPTH_WORDS(DMEM_WORDS)
    ) i_dmem (
        .clk     (clk),
        .addr    (dmem_addr),
        .byte_en (dmem_be),
        .wdata   (dmem_wdata),
        .rdata   (dmem_rdata)
    );

    // Lane extraction for loads
    assign load_byte = dmem_rdata[8*byte_off +: 8];
    assign load_half = byte_off[1] ? dmem_rdata[31:16] : dmem_rdata[15:0];

    always_comb begin
        case (ex_mem.funct3)
            rv_isa_pkg::f3_byte:   load_ext = {{24{load_byte[7]}}, load_byte};
            rv_isa_pkg::f3_half:   load_ext = {{16{load_half[15]}}, load_half};
            rv_isa_pkg::f3_byte_u: load_ext = {24'h0, load_byte};
            rv_isa_pkg::f3_half_u: load_ext = {16'h0, load_half};
            default:               load_ext = dmem_rdata;
        endcase
    end

    // Copy the rest of the instruction through
    always_comb begin
        mem_wb_d.reg_write      = ex_mem.reg_write;
        mem_wb_d.res_src        = ex_mem.res_src;
        mem_wb_d.funct3         = ex_mem.funct3;
        mem_wb_d.instr          = ex_mem.instr;
        mem_wb_d.rd             = ex_mem.rd;
        mem_wb_d.alu_result     = ex_mem.alu_result;
        // Only a load carries memory data forward
        mem_wb_d.dmem_rdata_ext = ex_mem.mem_read ? load_ext : '0;
        mem_wb_d.pc_plus4       = ex_mem.pc_plus4;
        mem_wb_d.jb_target      = ex_mem.jb_target;
        mem_wb_d.csr_rdata      = ex_mem.csr_rdata;
        mem_wb_d.m_result       = ex_mem.m_result;
    end

endmodule

//--- hw/rv_reg_mem_wb.sv
`timescale 1ns/1ns

module rv_reg_mem_wb #(
    parameter int PIPELINED = 1
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                stall,
    input  rv_pipe_pkg::memwb_t mem_wb_d,
    output rv_pipe_pkg::memwb_t mem_wb_q
);

    if (PIPELINED != 0) begin : g_registered

        rv_pipe_pkg::memwb_t q;

        // Whole struct advances unless the pipe is frozen
        always_ff @(posedge clk) begin
            if (!stall) begin
                q <= mem_wb_d;
            end
            // Reset overrides the control fields only
            if (!rst_n) begin
                q.reg_write <= 1'b0;
                q.funct3    <= '0;
                q.instr     <= rv_isa_pkg::instr_nop;
            end
        end

        assign mem_wb_q = q;

    end else begin : g_passthrough

        // Writeback sees the memory stage directly
        assign mem_wb_q = mem_wb_d;

    end

endmodule

//--- hw/rv_writeback.sv
`timescale 1ns/1ns

module rv_writeback (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv_pipe_pkg::memwb_t   mem_wb_q,
    input  rv_isa_pkg::reg_addr_t rs1_addr,
    input  rv_isa_pkg::reg_addr_t rs2_addr,
    output rv_isa_pkg::word_t     rs1_data,
    output rv_isa_pkg::word_t     rs2_data
);

    rv_isa_pkg::word_t regs [32];
    rv_isa_pkg::word_t result;
    logic              wr_en;

    // Result source select
    always_comb begin
        case (mem_wb_q.res_src)
            rv_isa_pkg::res_alu:       result = mem_wb_q.alu_result;
            rv_isa_pkg::res_dmem:      result = mem_wb_q.dmem_rdata_ext;
            rv_isa_pkg::res_pc_plus4:  result = mem_wb_q.pc_plus4;
            rv_isa_pkg::res_jb_target: result = mem_wb_q.jb_target;
            rv_isa_pkg::res_csr:       result = mem_wb_q.csr_rdata;
            rv_isa_pkg::res_m:         result = mem_wb_q.m_result;
            default:                   result = mem_wb_q.alu_result;
        endcase
    end

    // x0 is hardwired
    assign wr_en = mem_wb_q.reg_write && (mem_wb_q.rd != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[mem_wb_q.rd] <= result;
        end
    end

    // Decode read ports
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

//--- hw/rv_backend_top.sv
`timescale 1ns/1ns

module rv_backend_top #(
    parameter int PIPELINED  = 1,
    parameter int DMEM_WORDS = 256
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall,
    input  rv_pipe_pkg::exmem_t   ex_mem,
    input  rv_isa_pkg::reg_addr_t rs1_addr,
    input  rv_isa_pkg::reg_addr_t rs2_addr,
    output rv_isa_pkg::word_t     rs1_data,
    output rv_isa_pkg::word_t     rs2_data,
    output rv_isa_pkg::instr_t    retire_instr
);

    rv_pipe_pkg::memwb_t mem_wb_d;
    rv_pipe_pkg::memwb_t mem_wb_q;

    // Data memory access and load extension
    rv_mem_stage #(
        .DMEM_WORDS(DMEM_WORDS)
    ) i_mem_stage (
        .clk      (clk),
        .ex_mem   (ex_mem),
        .mem_wb_d (mem_wb_d)
    );

    // MEM to WB boundary
    rv_reg_mem_wb #(
        .PIPELINED(PIPELINED)
    ) i_reg_mem_wb (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .mem_wb_d (mem_wb_d),
        .mem_wb_q (mem_wb_q)
    );

    // Result select and register file
    rv_writeback i_writeback (
        .clk      (clk),
        .rst_n    (rst_n),
        .mem_wb_q (mem_wb_q),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // Instruction currently in writeback
    assign retire_instr = mem_wb_q.instr;

endmodule

//--- verif/tb_rv_backend.sv
`timescale 1ns/1ns

module tb_rv_backend;

    localparam int dmem_words = 256;
    localparam int n_slots    = 4;
    localparam int n_stall    = 4;
    // Clock cycles taken by the planned operations
    localparam int num_ops    = 3 + 1 + 15 + n_slots * 13 + 2 + (n_stall + 3);
    localparam time timeout   = (num_ops + 50) * 100;

    logic                  clk;
    logic                  rst_n;
    logic                  stall;
    rv_pipe_pkg::exmem_t   ex_mem;
    rv_isa_pkg::reg_addr_t rs1_addr;
    rv_isa_pkg::reg_addr_t rs2_addr;
    rv_isa_pkg::word_t     rs1_data;
    rv_isa_pkg::word_t     rs2_data;
    rv_isa_pkg::instr_t    retire_instr;

    // Reference model state
    rv_isa_pkg::word_t     model_regs [32];
    logic [7:0]            model_mem [dmem_words * 4];
    rv_isa_pkg::word_t     slot_base [n_slots];
    integer                seed;

    rv_backend_top #(
        .PIPELINED  (1),
        .DMEM_WORDS (dmem_words)
    ) i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall        (stall),
        .ex_mem       (ex_mem),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .retire_instr (retire_instr)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // Move to the drive point of the next cycle
    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    function automatic rv_pipe_pkg::exmem_t bubble();
        rv_pipe_pkg::exmem_t e;
        e       = '0;
        e.instr = rv_isa_pkg::instr_nop;
        return e;
    endfunction

    function automatic rv_isa_pkg::reg_addr_t rand_reg();
        return rv_isa_pkg::reg_addr_t'(({$random(seed)} % 31) + 1);
    endfunction

    // Random offset inside an aligned word, legal for the access size
    function automatic rv_isa_pkg::word_t lane_addr(rv_isa_pkg::word_t base,
                                                    rv_isa_pkg::funct3_t f3);
        rv_isa_pkg::word_t off;
        off = {$random(seed)};
        case (f3)
            rv_isa_pkg::f3_byte, rv_isa_pkg::f3_byte_u: return base + (off & 32'd3);
            rv_isa_pkg::f3_half, rv_isa_pkg::f3_half_u: return base + (off & 32'd2);
            default: return base;
        endcase
    endfunction

    // Register-writing instruction with every source field random
    function automatic rv_pipe_pkg::exmem_t reg_op(rv_isa_pkg::reg_addr_t rd,
                                                   rv_isa_pkg::res_src_t src);
        rv_pipe_pkg::exmem_t e;
        e            = bubble();
        e.reg_write  = 1'b1;
        e.res_src    = src;
        e.funct3     = rv_isa_pkg::f3_word;
        e.instr      = $random(seed);
        e.rd         = rd;
        e.alu_result = $random(seed);
        e.store_data = $random(seed);
        e.pc_plus4   = $random(seed);
        e.jb_target  = $random(seed);
        e.csr_rdata  = $random(seed);
        e.m_result   = $random(seed);
        return e;
    endfunction

    function automatic rv_isa_pkg::word_t model_load(rv_isa_pkg::word_t addr,
                                                     rv_isa_pkg::funct3_t f3);
        int                a;
        logic [7:0]        b;
        logic [15:0]       h;
        rv_isa_pkg::word_t w;
        a = int'(addr);
        b = model_mem[a];
        h = {model_mem[(a & ~1) + 1], model_mem[a & ~1]};
        w = {model_mem[(a & ~3) + 3], model_mem[(a & ~3) + 2],
             model_mem[(a & ~3) + 1], model_mem[a & ~3]};
        case (f3)
            rv_isa_pkg::f3_byte:   return {{24{b[7]}}, b};
            rv_isa_pkg::f3_half:   return {{16{h[15]}}, h};
            rv_isa_pkg::f3_byte_u: return {24'h0, b};
            rv_isa_pkg::f3_half_u: return {16'h0, h};
            default:               return w;
        endcase
    endfunction

    task automatic model_store(rv_isa_pkg::word_t addr, rv_isa_pkg::funct3_t f3,
                               rv_isa_pkg::word_t data);
        int a;
        a = int'(addr);
        case (f3)
            rv_isa_pkg::f3_byte: model_mem[a] = data[7:0];
            rv_isa_pkg::f3_half: begin
                model_mem[a & ~1]       = data[7:0];
                model_mem[(a & ~1) + 1] = data[15:8];
            end
            default: begin
                for (int i = 0; i < 4; i++) begin
                    model_mem[(a & ~3) + i] = data[8*i +: 8];
                end
            end
        endcase
    endtask

    // Value that writeback must pick for this instruction
    function automatic rv_isa_pkg::word_t selected_field(rv_pipe_pkg::exmem_t e,
                                                         rv_isa_pkg::word_t load_val);
        case (e.res_src)
            rv_isa_pkg::res_dmem:      return load_val;
            rv_isa_pkg::res_pc_plus4:  return e.pc_plus4;
            rv_isa_pkg::res_jb_target: return e.jb_target;
            rv_isa_pkg::res_csr:       return e.csr_rdata;
            rv_isa_pkg::res_m:         return e.m_result;
            default:                   return e.alu_result;
        endcase
    endfunction

    task automatic check_value(string name, rv_isa_pkg::word_t expected,
                               rv_isa_pkg::word_t actual);
        assert (actual === expected) else begin
            $display("[ERROR] time %0t: %s expected %h, actual %h",
                     $time, name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    // Both read ports look at the same register
    task automatic check_reg(rv_isa_pkg::reg_addr_t r, rv_isa_pkg::word_t expected);
        rs1_addr = r;
        rs2_addr = r;
        #1;
        check_value($sformatf("rs1_data x%0d", r), expected, rs1_data);
        check_value($sformatf("rs2_data x%0d", r), expected, rs2_data);
    endtask

    task automatic store_op(rv_isa_pkg::word_t addr, rv_isa_pkg::funct3_t f3,
                            rv_isa_pkg::word_t data);
        rv_pipe_pkg::exmem_t e;
        e            = reg_op(rand_reg(), rv_isa_pkg::res_alu);
        e.reg_write  = 1'b0;
        e.mem_write  = 1'b1;
        e.funct3     = f3;
        e.alu_result = addr;
        e.store_data = data;
        ex_mem = e;
        next_cycle();
        ex_mem = bubble();
        model_store(addr, f3, data);
    endtask

    // Present one instruction, wait two edges, then read back its destination
    task automatic exec_and_check(rv_pipe_pkg::exmem_t e);
        rv_isa_pkg::word_t load_val;
        rv_isa_pkg::word_t expected;
        load_val = e.mem_read ? model_load(e.alu_result, e.funct3) : '0;
        expected = selected_field(e, load_val);
        ex_mem = e;
        next_cycle();
        ex_mem = bubble();
        next_cycle();
        if (e.reg_write && e.rd != 0) begin
            model_regs[e.rd] = expected;
        end
        check_reg(e.rd, model_regs[e.rd]);
    endtask

    task automatic load_op(rv_isa_pkg::word_t addr, rv_isa_pkg::funct3_t f3);
        rv_pipe_pkg::exmem_t e;
        e            = reg_op(rand_reg(), rv_isa_pkg::res_dmem);
        e.mem_read   = 1'b1;
        e.funct3     = f3;
        e.alu_result = addr;
        exec_and_check(e);
    endtask

    initial begin
        rv_pipe_pkg::exmem_t   e;
        rv_pipe_pkg::exmem_t   held;
        rv_isa_pkg::reg_addr_t rd;
        rv_isa_pkg::word_t     addr;
        rv_isa_pkg::word_t     old_val;
        seed     = 57;
        rst_n    = 1'b0;
        stall    = 1'b0;
        rs1_addr = '0;
        rs2_addr = '0;
        // A register write sits on the input for the whole reset
        e        = reg_op(rand_reg(), rv_isa_pkg::res_alu);
        ex_mem   = e;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (3) @(posedge clk);
        #10;
        rst_n  = 1'b1;
        ex_mem = bubble();

        // Reset state
        check_value("retire_instr", rv_isa_pkg::instr_nop, retire_instr);
        for (int i = 0; i < 32; i++) begin
            rs1_addr = rv_isa_pkg::reg_addr_t'(i);
            rs2_addr = rv_isa_pkg::reg_addr_t'(31 - i);
            #1;
            check_value($sformatf("rs1_data x%0d", i), '0, rs1_data);
            check_value($sformatf("rs2_data x%0d", 31 - i), '0, rs2_data);
        end
        // The instruction seen during reset never reaches the register file
        next_cycle();
        check_reg(e.rd, '0);

        // Each result source, the memory one through a preloaded word
        for (int s = 0; s < 6; s++) begin
            e = reg_op(rand_reg(), rv_isa_pkg::res_src_t'(s));
            if (e.res_src == rv_isa_pkg::res_dmem) begin
                addr = ({$random(seed)} % dmem_words) * 4;
                store_op(addr, rv_isa_pkg::f3_word, $random(seed));
                e.mem_read   = 1'b1;
                e.alu_result = addr;
            end
            exec_and_check(e);
        end
        // Write aimed at x0
        exec_and_check(reg_op('0, rv_isa_pkg::res_alu));

        // Stores first, narrow ones land inside a known word
        for (int k = 0; k < n_slots; k++) begin
            slot_base[k] = ({$random(seed)} % dmem_words) * 4;
            store_op(slot_base[k], rv_isa_pkg::f3_word, $random(seed));
            store_op(lane_addr(slot_base[k], rv_isa_pkg::f3_byte),
                     rv_isa_pkg::f3_byte, $random(seed));
            store_op(lane_addr(slot_base[k], rv_isa_pkg::f3_half),
                     rv_isa_pkg::f3_half, $random(seed));
        end
        for (int k = 0; k < n_slots; k++) begin
            load_op(lane_addr(slot_base[k], rv_isa_pkg::f3_byte), rv_isa_pkg::f3_byte);
            load_op(lane_addr(slot_base[k], rv_isa_pkg::f3_byte_u), rv_isa_pkg::f3_byte_u);
            load_op(lane_addr(slot_base[k], rv_isa_pkg::f3_half), rv_isa_pkg::f3_half);
            load_op(lane_addr(slot_base[k], rv_isa_pkg::f3_half_u), rv_isa_pkg::f3_half_u);
            // Full word shows the bytes around the narrow stores
            load_op(slot_base[k], rv_isa_pkg::f3_word);
        end

        // Latency of exactly two edges
        rd      = rand_reg();
        old_val = model_regs[rd];
        e       = reg_op(rd, rv_isa_pkg::res_alu);
        if (e.alu_result == old_val) begin
            e.alu_result = ~old_val;
        end
        ex_mem = e;
        next_cycle();
        ex_mem = bubble();
        check_reg(rd, old_val);
        next_cycle();
        model_regs[rd] = e.alu_result;
        check_reg(rd, model_regs[rd]);

        // Older instruction sits in writeback while the next one is stalled
        e      = reg_op(rand_reg(), rv_isa_pkg::res_csr);
        ex_mem = e;
        next_cycle();
        model_regs[e.rd] = e.csr_rdata;
        do begin
            rd = rand_reg();
        end while (rd == e.rd);
        held = reg_op(rd, rv_isa_pkg::res_pc_plus4);
        if (held.pc_plus4 == model_regs[rd]) begin
            held.pc_plus4 = ~model_regs[rd];
        end
        stall  = 1'b1;
        ex_mem = held;
        check_value("retire_instr", e.instr, retire_instr);
        repeat (n_stall) begin
            next_cycle();
            check_value("retire_instr", e.instr, retire_instr);
            check_reg(e.rd, model_regs[e.rd]);
            check_reg(held.rd, model_regs[held.rd]);
        end
        stall = 1'b0;
        next_cycle();
        ex_mem = bubble();
        check_value("retire_instr", held.instr, retire_instr);
        check_reg(held.rd, model_regs[held.rd]);
        next_cycle();
        model_regs[held.rd] = held.pc_plus4;
        check_reg(held.rd, model_regs[held.rd]);

        $display("*** PASSED ***");
        $finish;
    end

    // Watchdog
    initial begin
        #(timeout);
        $display("Timeout: the test sequence did not finish within %0t", timeout);
        $display("*** FAILED ***");
        $fatal(1);
    end

endmodule

//--- verilog.f
common/rv_isa_pkg.sv
common/rv_pipe_pkg.sv
hw/mem/rv_dmem.sv
hw/mem/rv_mem_stage.sv
hw/rv_reg_mem_wb.sv
hw/rv_writeback.sv
hw/rv_backend_top.sv
verif/tb_rv_backend.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the backend testbench with Verilator, then judge the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f verilog.f --top-module tb_rv_backend \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/Vtb_rv_backend > sim.log 2>&1 || echo "Simulator returned an error status"
cat sim.log

grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "Simulation failed"; exit 1; }
grep -q '\*\*\* PASSED \*\*\*' sim.log || { echo "No pass message in the log"; exit 1; }
echo "Simulation passed"
